/* all.f */
common/soc_pkg.sv
src/ahb_decoder.sv
sram/ahb_sram.sv
timer/ahb_timer.sv
src/ahb_gpio.sv
src/ahb_soc.sv
verif/tb_ahb_soc.sv

/* Makefile */
TOP             ?= tb_ahb_soc
LOG             ?= sim.log
FLIST           ?= all.f
BUILD_DIR       ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VERILATOR_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --binary -f $(FLIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG) && echo "simulation passed" || \
		{ echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/tb_ahb_soc.sv */
`timescale 1ns/1ps

module tb_ahb_soc
    import soc_pkg::*;
();

    localparam int READY_TIMEOUT = 16;
    localparam int IRQ_TIMEOUT   = 40;
    localparam int STATUS_POLLS  = 30;
    localparam int TMR_CMP_VAL   = 20;

    logic     clk = 1'b0;
    logic     arst_n;
    ahb_req_t ahb_req;
    ahb_rsp_t ahb_rsp;
    gpio_t    gpio_in;
    gpio_t    gpio_out;
    logic     timer_irq;
    word_t    rng_state = 32'd89;

    ahb_soc dut (
        .clk         (clk),
        .arst_n_i    (arst_n),
        .ahb_req_i   (ahb_req),
        .gpio_i      (gpio_in),
        .ahb_rsp_o   (ahb_rsp),
        .timer_irq_o (timer_irq),
        .gpio_o      (gpio_out)
    );

    initial begin
        forever #2 clk = ~clk;
    end

    function automatic word_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic addr_t sram_addr(input logic [SRAM_AW-1:0] word_idx);
        return SRAM_BASE + addr_t'({word_idx, 2'b00});
    endfunction

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
        if (exp !== act) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // called at a falling edge, returns at the falling edge with hready high
    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        while (ahb_rsp.hready !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > READY_TIMEOUT) begin
                $display("timeout: hready did not rise during the %s", what);
                abort_run();
            end
        end
    endtask

    task automatic ahb_write(input addr_t addr, input word_t data);
        @(negedge clk);
        ahb_req.htrans = HTRANS_NONSEQ;
        ahb_req.haddr  = addr;
        ahb_req.hwrite = 1'b1;
        wait_ready("write address phase");
        @(negedge clk);
        ahb_req.htrans = HTRANS_IDLE;
        ahb_req.hwdata = data;
        wait_ready("write data phase");
    endtask

    // second address phase overlaps the first data phase
    task automatic ahb_write_pair(input addr_t a0, input word_t d0,
                                  input addr_t a1, input word_t d1);
        @(negedge clk);
        ahb_req.htrans = HTRANS_NONSEQ;
        ahb_req.haddr  = a0;
        ahb_req.hwrite = 1'b1;
        wait_ready("first write address phase");
        @(negedge clk);
        ahb_req.haddr  = a1;
        ahb_req.hwdata = d0;
        wait_ready("first write data phase");
        @(negedge clk);
        ahb_req.htrans = HTRANS_IDLE;
        ahb_req.hwdata = d1;
        wait_ready("second write data phase");
    endtask

    task automatic ahb_read(input addr_t addr, output word_t data, output logic resp);
        @(negedge clk);
        ahb_req.htrans = HTRANS_NONSEQ;
        ahb_req.haddr  = addr;
        ahb_req.hwrite = 1'b0;
        wait_ready("read address phase");
        @(negedge clk);
        ahb_req.htrans = HTRANS_IDLE;
        wait_ready("read data phase");
        data = ahb_rsp.hrdata;
        resp = ahb_rsp.hresp;
    endtask

    task automatic reset_test();
        check_flag("reset hready", 1'b1, ahb_rsp.hready);
        check_flag("reset hresp", 1'b0, ahb_rsp.hresp);
        check_flag("reset timer_irq", 1'b0, timer_irq);
        check_gpio("reset gpio_o", '0, gpio_out);
    endtask

    task automatic sram_test();
        word_t              model [2**SRAM_AW];
        logic [SRAM_AW-1:0] idx [16];
        word_t              r;
        word_t              d0;
        word_t              d1;
        word_t              data;
        logic               resp;
        for (int i = 0; i < 8; i++) begin
            r = next_rand();
            idx[2*i]   = r[SRAM_AW-1:0];
            idx[2*i+1] = r[2*SRAM_AW-1:SRAM_AW];
            d0 = next_rand();
            d1 = next_rand();
            if (i % 2 == 0) begin
                ahb_write_pair(sram_addr(idx[2*i]), d0, sram_addr(idx[2*i+1]), d1);
            end else begin
                ahb_write(sram_addr(idx[2*i]), d0);
                ahb_write(sram_addr(idx[2*i+1]), d1);
            end
            model[idx[2*i]]   = d0;
            model[idx[2*i+1]] = d1;
        end
        for (int i = 0; i < 16; i++) begin
            ahb_read(sram_addr(idx[i]), data, resp);
            check_flag("sram read hresp", 1'b0, resp);
            check_word("sram readback", model[idx[i]], data);
        end
    endtask

    task automatic gpio_test();
        word_t r;
        gpio_t out_val;
        gpio_t in_val;
        word_t data;
        logic  resp;
        r = next_rand();
        out_val = r[GPIO_W-1:0];
        in_val  = r[2*GPIO_W-1:GPIO_W];
        ahb_write(GPIO_BASE + addr_t'(GPIO_OUT), word_t'(out_val));
        @(negedge clk);
        check_gpio("gpio_o after write", out_val, gpio_out);
        ahb_read(GPIO_BASE + addr_t'(GPIO_OUT), data, resp);
        check_word("gpio out readback", word_t'(out_val), data);
        gpio_in = in_val;
        // two synchronizer flops plus margin
        repeat (3) @(negedge clk);
        ahb_read(GPIO_BASE + addr_t'(GPIO_IN), data, resp);
        check_word("gpio in read", word_t'(in_val), data);
        ahb_write(GPIO_BASE + addr_t'(GPIO_IN), word_t'(~in_val));
        ahb_read(GPIO_BASE + addr_t'(GPIO_IN), data, resp);
        check_word("gpio in after write", word_t'(in_val), data);
        ahb_read(GPIO_BASE + addr_t'(GPIO_OUT), data, resp);
        check_word("gpio out after in write", word_t'(out_val), data);
        check_gpio("gpio_o after in write", out_val, gpio_out);
    endtask

    task automatic timer_test();
        int    cycles;
        int    polls;
        word_t data;
        logic  resp;
        ahb_write(TIMER_BASE + addr_t'(TMR_CMP), word_t'(TMR_CMP_VAL));
        ahb_write(TIMER_BASE + addr_t'(TMR_CTRL), 32'h3);
        cycles = 0;
        while (timer_irq !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > IRQ_TIMEOUT) begin
                $display("timeout: timer_irq_o did not rise after the timer was enabled");
                abort_run();
            end
        end
        // counting from zero up to the compare value takes at least that many cycles
        if (cycles < TMR_CMP_VAL) begin
            $display("ERR timer irq delay: expected at least %0d cycles, actual %0d",
                     TMR_CMP_VAL, cycles);
            abort_run();
        end
        ahb_read(TIMER_BASE + addr_t'(TMR_STATUS), data, resp);
        check_word("timer status set", 32'h1, data);
        ahb_write(TIMER_BASE + addr_t'(TMR_STATUS), 32'h1);
        @(negedge clk);
        check_flag("timer irq after clear", 1'b0, timer_irq);
        // counting goes on with irq enable off
        ahb_write(TIMER_BASE + addr_t'(TMR_CTRL), 32'h1);
        ahb_write(TIMER_BASE + addr_t'(TMR_STATUS), 32'h1);
        polls = 0;
        data  = '0;
        while (data[0] !== 1'b1) begin
            if (polls == STATUS_POLLS) begin
                $display("timeout: timer match flag did not set with irq enable off");
                abort_run();
            end
            ahb_read(TIMER_BASE + addr_t'(TMR_STATUS), data, resp);
            polls++;
        end
        check_flag("timer irq masked", 1'b0, timer_irq);
    endtask

    task automatic error_test();
        word_t val;
        word_t data;
        logic  resp;
        val = next_rand();
        ahb_write(SRAM_BASE + 32'h40, val);
        @(negedge clk);
        ahb_req.htrans = HTRANS_NONSEQ;
        ahb_req.haddr  = 32'h7000_0000;
        ahb_req.hwrite = 1'b0;
        wait_ready("unmapped address phase");
        @(negedge clk);
        ahb_req.htrans = HTRANS_IDLE;
        check_flag("error first cycle hresp", 1'b1, ahb_rsp.hresp);
        check_flag("error first cycle hready", 1'b0, ahb_rsp.hready);
        @(negedge clk);
        check_flag("error second cycle hresp", 1'b1, ahb_rsp.hresp);
        check_flag("error second cycle hready", 1'b1, ahb_rsp.hready);
        ahb_read(SRAM_BASE + 32'h40, data, resp);
        check_flag("sram after error hresp", 1'b0, resp);
        check_word("sram after error data", val, data);
    endtask

    initial begin
        arst_n  = 1'b0;
        ahb_req = '0;
        gpio_in = '0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        reset_test();
        sram_test();
        gpio_test();
        timer_test();
        error_test();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* src/ahb_soc.sv */
`timescale 1ns/1ps

module ahb_soc
    import soc_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  ahb_req_t ahb_req_i,
    input  gpio_t    gpio_i,
    output ahb_rsp_t ahb_rsp_o,
    output logic     timer_irq_o,
    output gpio_t    gpio_o
);

    ahb_rsp_t         slv_rsp [N_SLV];
    logic [N_SLV-1:0] slv_sel;
    logic             slv_hready;

    ahb_decoder u_ahb_decoder (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .mst_req_i    (ahb_req_i),
        .slv_rsp_i    (slv_rsp),
        .mst_rsp_o    (ahb_rsp_o),
        .slv_sel_o    (slv_sel),
        .slv_hready_o (slv_hready)
    );

    // request fans out unchanged, select picks the slave
    ahb_sram u_ahb_sram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (ahb_req_i),
        .sel_i    (slv_sel[SLV_SRAM]),
        .hready_i (slv_hready),
        .rsp_o    (slv_rsp[SLV_SRAM])
    );

    ahb_timer u_ahb_timer (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .req_i       (ahb_req_i),
        .sel_i       (slv_sel[SLV_TIMER]),
        .hready_i    (slv_hready),
        .rsp_o       (slv_rsp[SLV_TIMER]),
        .timer_irq_o (timer_irq_o)
    );

    ahb_gpio u_ahb_gpio (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .req_i    (ahb_req_i),
        .sel_i    (slv_sel[SLV_GPIO]),
        .hready_i (slv_hready),
        .gpio_i   (gpio_i),
        .rsp_o    (slv_rsp[SLV_GPIO]),
        .gpio_o   (gpio_o)
    );

endmodule

/* src/ahb_gpio.sv */
`timescale 1ns/1ps

module ahb_gpio
    import soc_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  ahb_req_t req_i,
    input  logic     sel_i,
    input  logic     hready_i,
    input  gpio_t    gpio_i,
    output ahb_rsp_t rsp_o,
    output gpio_t    gpio_o
);

    gpio_t                out_q;
    gpio_t                sync1_q;
    gpio_t                sync2_q;
    logic [REG_OFF_W-1:0] off_q;
    logic                 wr_q;
    logic                 accept;

    assign accept = sel_i && hready_i && (req_i.htrans == HTRANS_NONSEQ);

    always_ff @(posedge clk) begin
        if (accept) begin
            off_q <= req_i.haddr[REG_OFF_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_q    <= 1'b0;
            out_q   <= '0;
            sync1_q <= '0;
            sync2_q <= '0;
        end else begin
            if (hready_i) begin
                wr_q <= accept && req_i.hwrite;
            end
            // only the output register is writable
            if (wr_q && hready_i && (off_q == GPIO_OUT)) begin
                out_q <= req_i.hwdata[GPIO_W-1:0];
            end
            // two flop sync on the pins
            sync1_q <= gpio_i;
            sync2_q <= sync1_q;
        end
    end

    assign rsp_o.hready = 1'b1;
    assign rsp_o.hresp  = 1'b0;
    assign rsp_o.hrdata = (off_q == GPIO_OUT) ? word_t'(out_q) :
                          (off_q == GPIO_IN)  ? word_t'(sync2_q) : '0;

    assign gpio_o = out_q;

endmodule

/* timer/ahb_timer.sv */
`timescale 1ns/1ps

module ahb_timer
    import soc_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  ahb_req_t req_i,
    input  logic     sel_i,
    input  logic     hready_i,
    output ahb_rsp_t rsp_o,
    output logic     timer_irq_o
);

    typedef struct packed {
        logic irq_en;
        logic en;
    } tmr_ctrl_t;

    tmr_ctrl_t            ctrl_q;
    word_t                cmp_q;
    word_t                count_q;
    logic                 match_q;
    logic [REG_OFF_W-1:0] off_q;
    logic                 wr_q;
    logic                 accept;
    word_t                rdata;

    assign accept = sel_i && hready_i && (req_i.htrans == HTRANS_NONSEQ);

    always_ff @(posedge clk) begin
        if (accept) begin
            off_q <= req_i.haddr[REG_OFF_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_q    <= 1'b0;
            ctrl_q  <= '0;
            cmp_q   <= '0;
            count_q <= '0;
            match_q <= 1'b0;
        end else begin
            if (hready_i) begin
                wr_q <= accept && req_i.hwrite;
            end
            if (wr_q && hready_i) begin
                case (off_q)
                    TMR_CTRL:   ctrl_q <= tmr_ctrl_t'(req_i.hwdata[1:0]);
                    TMR_CMP:    cmp_q  <= req_i.hwdata;
                    TMR_STATUS: if (req_i.hwdata[0]) match_q <= 1'b0;
                    default:    ;
                endcase
            end
            // a new match wins over a clear in the same cycle
            if (ctrl_q.en) begin
                if (count_q == cmp_q) begin
                    count_q <= '0;
                    match_q <= 1'b1;
                end else begin
                    count_q <= count_q + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (off_q)
            TMR_CTRL:   rdata = word_t'(ctrl_q);
            TMR_CMP:    rdata = cmp_q;
            TMR_COUNT:  rdata = count_q;
            TMR_STATUS: rdata = word_t'(match_q);
            default:    rdata = '0;
        endcase
    end

    assign rsp_o.hready = 1'b1;
    assign rsp_o.hresp  = 1'b0;
    assign rsp_o.hrdata = rdata;

    // level irq until the flag is cleared
    assign timer_irq_o = match_q && ctrl_q.irq_en;

endmodule

/* sram/ahb_sram.sv */
`timescale 1ns/1ps

module ahb_sram
    import soc_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,
    input  ahb_req_t req_i,
    input  logic     sel_i,
    input  logic     hready_i,
    output ahb_rsp_t rsp_o
);

    word_t              mem [2**SRAM_AW];
    logic [SRAM_AW-1:0] addr_q;
    logic               wr_q;
    logic               accept;

    assign accept = sel_i && hready_i && (req_i.htrans == HTRANS_NONSEQ);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_q <= 1'b0;
        end else if (hready_i) begin
            wr_q <= accept && req_i.hwrite;
        end
    end

    // byte offset dropped from the word address
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= req_i.haddr[SRAM_AW+1:2];
        end
    end

    // write lands at the end of the data phase
    always_ff @(posedge clk) begin
        if (wr_q && hready_i) begin
            mem[addr_q] <= req_i.hwdata;
        end
    end

    // always OKAY with no wait states
    assign rsp_o.hready = 1'b1;
    assign rsp_o.hresp  = 1'b0;
    assign rsp_o.hrdata = mem[addr_q];

endmodule

/* src/ahb_decoder.sv */
`timescale 1ns/1ps

module ahb_decoder
    import soc_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n_i,
    input  ahb_req_t         mst_req_i,
    input  ahb_rsp_t         slv_rsp_i [N_SLV],
    output ahb_rsp_t         mst_rsp_o,
    output logic [N_SLV-1:0] slv_sel_o,
    output logic             slv_hready_o
);

    slave_id_t addr_slv;
    slave_id_t dphase_slv_q;
    logic      dphase_vld_q;
    logic      err_wait_q;
    logic      accept;
    ahb_rsp_t  rsp;

    // address phase decode
    always_comb begin
        case (mst_req_i.haddr & REGION_MASK)
            SRAM_BASE:  addr_slv = SLV_SRAM;
            TIMER_BASE: addr_slv = SLV_TIMER;
            GPIO_BASE:  addr_slv = SLV_GPIO;
            default:    addr_slv = SLV_NONE;
        endcase
    end

    assign slv_sel_o[SLV_SRAM]  = (addr_slv == SLV_SRAM);
    assign slv_sel_o[SLV_TIMER] = (addr_slv == SLV_TIMER);
    assign slv_sel_o[SLV_GPIO]  = (addr_slv == SLV_GPIO);

    assign accept = (mst_req_i.htrans == HTRANS_NONSEQ) && slv_hready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dphase_vld_q <= 1'b0;
            dphase_slv_q <= SLV_NONE;
            err_wait_q   <= 1'b0;
        end else begin
            // first error cycle holds the master
            err_wait_q <= accept && (addr_slv == SLV_NONE);
            if (slv_hready_o) begin
                dphase_vld_q <= accept;
                dphase_slv_q <= accept ? addr_slv : SLV_NONE;
            end
        end
    end

    // data phase response mux
    always_comb begin
        rsp.hready = 1'b1;
        rsp.hresp  = 1'b0;
        rsp.hrdata = '0;
        case (dphase_slv_q)
            SLV_SRAM:  rsp = slv_rsp_i[SLV_SRAM];
            SLV_TIMER: rsp = slv_rsp_i[SLV_TIMER];
            SLV_GPIO:  rsp = slv_rsp_i[SLV_GPIO];
            default: begin
                if (dphase_vld_q) begin
                    rsp.hresp  = 1'b1;
                    rsp.hready = !err_wait_q;
                end
            end
        endcase
    end

    assign mst_rsp_o    = rsp;
    assign slv_hready_o = rsp.hready;

endmodule

/* common/soc_pkg.sv */
package soc_pkg;

    // bus widths
    localparam int HADDR_W = 32;
    localparam int HDATA_W = 32;

    typedef logic [HADDR_W-1:0] addr_t;
    typedef logic [HDATA_W-1:0] word_t;

    // top nibble picks the memory region
    localparam addr_t REGION_MASK = 32'hF000_0000;
    localparam addr_t SRAM_BASE   = 32'h0000_0000;
    localparam addr_t TIMER_BASE  = 32'h4000_0000;
    localparam addr_t GPIO_BASE   = 32'h5000_0000;

    // 256 words of sram
    localparam int SRAM_AW = 8;

    localparam int GPIO_W = 8;
    typedef logic [GPIO_W-1:0] gpio_t;

    // peripheral register offsets
    localparam int REG_OFF_W = 4;

    localparam logic [REG_OFF_W-1:0] TMR_CTRL   = 4'h0;
    localparam logic [REG_OFF_W-1:0] TMR_CMP    = 4'h4;
    localparam logic [REG_OFF_W-1:0] TMR_COUNT  = 4'h8;
    localparam logic [REG_OFF_W-1:0] TMR_STATUS = 4'hC;

    localparam logic [REG_OFF_W-1:0] GPIO_OUT = 4'h0;
    localparam logic [REG_OFF_W-1:0] GPIO_IN  = 4'h4;

    localparam logic [1:0] HTRANS_IDLE   = 2'b00;
    localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

    typedef enum logic [1:0] {
        SLV_SRAM  = 2'd0,
        SLV_TIMER = 2'd1,
        SLV_GPIO  = 2'd2,
        SLV_NONE  = 2'd3
    } slave_id_t;

    localparam int N_SLV = 3;

    typedef struct packed {
        logic [1:0] htrans;
        addr_t      haddr;
        logic       hwrite;
        word_t      hwdata;
    } ahb_req_t;

    // hready acts as hreadyout on the slave side
    typedef struct packed {
        logic  hready;
        logic  hresp;
        word_t hrdata;
    } ahb_rsp_t;

endpackage
